// ==== tb.f ====
+incdir+hw
hw/fml_pkg.sv
hw/fml_arbiter.sv
hw/fml_sram.sv
hw/scan_fetch.sv
hw/host_bridge.sv
hw/fml_meter.sv
hw/fml_memsys.sv
verification/tb_fml_memsys.sv

// ==== Bender.yml ====
package:
  name: fml_memsys

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/fml_pkg.sv
      - hw/fml_arbiter.sv
      - hw/fml_sram.sv
      - hw/scan_fetch.sv
      - hw/host_bridge.sv
      - hw/fml_meter.sv
      - hw/fml_memsys.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/tb_fml_memsys.sv

// ==== verification/tb_fml_memsys.sv ====
/*
 * Testbench for the shared memory link: random host traffic, scan passes,
 * contention and the usage meter, checked against a byte model
 */
`timescale 1ns/1ps
`include "fml_settings.svh"

module tb_fml_memsys import fml_pkg::*; ();

	localparam int HOST_WAIT_MAX = 100;
	localparam int SCAN_WAIT_MAX = 4000;
	localparam int BUSY_POLL_MAX = 50;
	localparam int BYTES = 8 * (2**`FML_DEPTH);

	logic sys_clk;
	logic hard_reset;
	csr_adr_t csr_adr_i;
	logic csr_we_i;
	csr_data_t csr_wdata_i;
	csr_data_t csr_rdata_o;
	logic host_stb_i;
	host_req_t host_req_i;
	logic host_ack_o;
	host_data_t host_rdata_o;
	logic scan_valid_o;
	fml_data_t scan_data_o;

	// Byte image of host writes, little endian within a link word
	logic [7:0] model_mem [BYTES];
	bit model_known [BYTES];
	host_adr_t written_q [$];
	fml_data_t scan_q [$];
	int errors;
	int timeouts;
	int host_ops;

	fml_memsys fml_memsys_inst (.*);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	// Stream collector, sampled away from the rising edge
	always @(negedge sys_clk) begin
		if (!hard_reset && scan_valid_o) begin
			scan_q.push_back(scan_data_o);
		end
	end

	// ----------------------------------------
	// Model and compare
	// ----------------------------------------
	task automatic model_write(input host_adr_t adr, input host_sel_t sel,
		input host_data_t data);
		for (int i = 0; i < 4; i++) begin
			if (sel[i]) begin
				model_mem[int'(adr) * 4 + i] = data[i*8 +: 8];
				model_known[int'(adr) * 4 + i] = 1'b1;
			end
		end
	endtask

	// Bytes never written are skipped
	task automatic check_bytes(input int base, input int nbytes, input fml_data_t got,
		input string what);
		bit bad;
		fml_data_t exp;
		bad = 1'b0;
		exp = '0;
		for (int i = 0; i < nbytes; i++) begin
			exp[i*8 +: 8] = model_mem[base + i];
			if (model_known[base + i] && (got[i*8 +: 8] !== model_mem[base + i])) begin
				bad = 1'b1;
			end
		end
		if (bad) begin
			$display("ERROR at %0t: %s at byte %0d got %h expected %h",
				$time, what, base, got, exp);
			errors++;
		end
	endtask

	// ----------------------------------------
	// Bus drivers
	// ----------------------------------------
	task automatic host_access(input host_adr_t adr, input logic we, input host_sel_t sel,
		input host_data_t wdata, output host_data_t rdata);
		int n;
		n = 0;
		@(posedge sys_clk);
		#1;
		host_stb_i = 1'b1;
		host_req_i = '{adr: adr, we: we, sel: sel, wdata: wdata};
		do begin
			@(posedge sys_clk);
			#1;
			n++;
		end while (!host_ack_o && (n < HOST_WAIT_MAX));
		if (!host_ack_o) begin
			$display("Timeout: host access to address %h never acknowledged", adr);
			timeouts++;
			rdata = 'x;
			host_stb_i = 1'b0;
		end else begin
			rdata = host_rdata_o;
			host_ops++;
			// Strobe drops in the cycle after the ack
			@(posedge sys_clk);
			#1;
			host_stb_i = 1'b0;
		end
	endtask

	function automatic csr_adr_t csr_addr(input int bank, input int idx);
		return csr_adr_t'((bank << (`CSR_ADR_W - `CSR_BANK_W)) | idx);
	endfunction

	task automatic csr_write(input csr_adr_t adr, input csr_data_t data);
		@(posedge sys_clk);
		#1;
		csr_adr_i = adr;
		csr_we_i = 1'b1;
		csr_wdata_i = data;
		@(posedge sys_clk);
		#1;
		csr_adr_i = '0;
		csr_we_i = 1'b0;
	endtask

	// Read data shows up one cycle after the address
	task automatic csr_read(input csr_adr_t adr, output csr_data_t data);
		@(posedge sys_clk);
		#1;
		csr_adr_i = adr;
		csr_we_i = 1'b0;
		@(posedge sys_clk);
		#1;
		data = csr_rdata_o;
		csr_adr_i = '0;
	endtask

	task automatic expect_csr(input csr_adr_t adr, input csr_data_t exp, input string what);
		csr_data_t got;
		csr_read(adr, got);
		if (got !== exp) begin
			$display("ERROR at %0t: %s read %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// ----------------------------------------
	// Scenarios
	// ----------------------------------------
	// Random write, or read of a word written before
	task automatic host_random_op(input bit upper_only);
		host_adr_t adr;
		host_sel_t sel;
		host_data_t wdata;
		host_data_t rdata;
		if ((written_q.size() > 0) && ($urandom_range(1, 0) == 1)) begin
			adr = written_q[$urandom_range(written_q.size() - 1, 0)];
			host_access(adr, 1'b0, 4'hf, '0, rdata);
			check_bytes(int'(adr) * 4, 4, fml_data_t'(rdata), "host read");
		end else begin
			adr = host_adr_t'($urandom);
			// Keeps writes out of a running scan block
			if (upper_only) begin
				adr[`FML_DEPTH] = 1'b1;
			end
			sel = host_sel_t'($urandom_range(15, 1));
			wdata = $urandom;
			host_access(adr, 1'b1, sel, wdata, rdata);
			model_write(adr, sel, wdata);
			written_q.push_back(adr);
		end
	endtask

	task automatic fill_block(input int base, input int count);
		host_data_t wdata;
		host_data_t rdata;
		for (int w = base; w < base + count; w++) begin
			for (int h = 0; h < 2; h++) begin
				wdata = $urandom;
				host_access(host_adr_t'(w * 2 + h), 1'b1, 4'hf, wdata, rdata);
				model_write(host_adr_t'(w * 2 + h), 4'hf, wdata);
			end
		end
	endtask

	task automatic start_scan(input int base, input int count);
		scan_q.delete();
		csr_write(csr_addr(`SCAN_CSR_BANK, 1), base);
		csr_write(csr_addr(`SCAN_CSR_BANK, 2), count);
		csr_write(csr_addr(`SCAN_CSR_BANK, 0), 32'h1);
	endtask

	// Whole stream, then busy must clear
	task automatic finish_scan(input int base, input int count);
		csr_data_t status;
		int n;
		n = 0;
		while ((scan_q.size() < count) && (n < SCAN_WAIT_MAX)) begin
			@(posedge sys_clk);
			n++;
		end
		if (scan_q.size() < count) begin
			$display("Timeout: scan pass gave %0d of %0d words", scan_q.size(), count);
			timeouts++;
		end
		n = 0;
		status = 32'h1;
		while (status[0] && (n < BUSY_POLL_MAX)) begin
			csr_read(csr_addr(`SCAN_CSR_BANK, 0), status);
			n++;
		end
		if (status[0]) begin
			$display("Timeout: scan reader still busy after its pass");
			timeouts++;
		end
		if (scan_q.size() != count) begin
			$display("ERROR at %0t: scan gave %0d words expected %0d",
				$time, scan_q.size(), count);
			errors++;
		end
		for (int i = 0; (i < scan_q.size()) && (i < count); i++) begin
			check_bytes((base + i) * 8, 8, scan_q[i], "scan word");
		end
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		int base;
		int count;
		int ops_at_clear;
		csr_data_t stb_cnt;
		csr_data_t ack_cnt;
		void'($urandom(84832));
		errors = 0;
		timeouts = 0;
		host_ops = 0;
		hard_reset = 1'b1;
		csr_adr_i = '0;
		csr_we_i = 1'b0;
		csr_wdata_i = '0;
		host_stb_i = 1'b0;
		host_req_i = '0;
		repeat (4) @(posedge sys_clk);
		#1;
		hard_reset = 1'b0;

		// Reset state
		if (host_ack_o !== 1'b0 || scan_valid_o !== 1'b0) begin
			$display("ERROR at %0t: host ack or scan valid high after reset", $time);
			errors++;
		end
		expect_csr(csr_addr(`METER_CSR_BANK, 0), '0, "meter strobe count");
		expect_csr(csr_addr(`METER_CSR_BANK, 1), '0, "meter ack count");
		expect_csr(csr_addr(`SCAN_CSR_BANK, 0), '0, "scan status");

		// Host traffic on its own
		repeat (200) host_random_op(1'b0);

		// Plain scan pass over a fresh block
		count = $urandom_range(32, 1);
		base = $urandom_range(2**`FML_DEPTH - count, 0);
		fill_block(base, count);
		start_scan(base, count);
		finish_scan(base, count);

		// Host traffic while a longer pass holds the link
		count = $urandom_range(64, 32);
		base = $urandom_range(2**(`FML_DEPTH - 1) - 64, 0);
		fill_block(base, count);
		start_scan(base, count);
		repeat (20) host_random_op(1'b1);
		finish_scan(base, count);

		// Meter over a known mix of transfers
		csr_write(csr_addr(`METER_CSR_BANK, 0), $urandom);
		ops_at_clear = host_ops;
		repeat (10) host_random_op(1'b1);
		count = $urandom_range(16, 1);
		start_scan(base, count);
		finish_scan(base, count);
		csr_read(csr_addr(`METER_CSR_BANK, 0), stb_cnt);
		csr_read(csr_addr(`METER_CSR_BANK, 1), ack_cnt);
		if (ack_cnt != csr_data_t'(host_ops - ops_at_clear + count)) begin
			$display("ERROR at %0t: meter acks %0d expected %0d",
				$time, ack_cnt, host_ops - ops_at_clear + count);
			errors++;
		end
		if (stb_cnt < (`SRAM_LATENCY + 1) * ack_cnt) begin
			$display("ERROR at %0t: meter strobes %0d too low for %0d acks",
				$time, stb_cnt, ack_cnt);
			errors++;
		end
		csr_write(csr_addr(`METER_CSR_BANK, 1), '0);
		expect_csr(csr_addr(`METER_CSR_BANK, 0), '0, "cleared strobe count");
		expect_csr(csr_addr(`METER_CSR_BANK, 1), '0, "cleared ack count");

		$display("Summary: %0d errors, %0d timeouts, %0d host accesses",
			errors, timeouts, host_ops);
		if ((errors == 0) && (timeouts == 0)) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== hw/fml_memsys.sv ====
/*
 * Shared memory link: scanout reader and host bridge on one 64-bit memory
 */
`timescale 1ns/1ps

module fml_memsys import fml_pkg::*; (
	input  logic       sys_clk,
	input  logic       hard_reset,
	input  csr_adr_t   csr_adr_i,
	input  logic       csr_we_i,
	input  csr_data_t  csr_wdata_i,
	output csr_data_t  csr_rdata_o,
	input  logic       host_stb_i,
	input  host_req_t  host_req_i,
	output logic       host_ack_o,
	output host_data_t host_rdata_o,
	output logic       scan_valid_o,
	output fml_data_t  scan_data_o
);

	// ----------------------------------------
	// Link wires
	// ----------------------------------------
	logic scan_stb, scan_ack;
	fml_req_t scan_req;
	logic brg_stb, brg_ack;
	fml_req_t brg_req;
	logic mem_stb, mem_ack;
	fml_req_t mem_req;
	// Read data is shared by both masters
	fml_data_t mem_rdata;
	csr_data_t csr_rdata_scan, csr_rdata_meter;

	// Framebuffer fetch, high priority
	scan_fetch scan_fetch_inst (
		.sys_clk, .hard_reset,
		.csr_adr_i, .csr_we_i, .csr_wdata_i,
		.csr_rdata_o(csr_rdata_scan),
		.fml_stb_o(scan_stb), .fml_req_o(scan_req),
		.fml_ack_i(scan_ack), .fml_rdata_i(mem_rdata),
		.scan_valid_o, .scan_data_o
	);

	host_bridge host_bridge_inst (
		.sys_clk, .hard_reset,
		.host_stb_i, .host_req_i, .host_ack_o, .host_rdata_o,
		.fml_stb_o(brg_stb), .fml_req_o(brg_req),
		.fml_ack_i(brg_ack), .fml_rdata_i(mem_rdata)
	);

	fml_arbiter fml_arbiter_inst (
		.sys_clk, .hard_reset,
		.scan_stb_i(scan_stb), .scan_req_i(scan_req), .scan_ack_o(scan_ack),
		.host_stb_i(brg_stb), .host_req_i(brg_req), .host_ack_o(brg_ack),
		.mem_stb_o(mem_stb), .mem_req_o(mem_req), .mem_ack_i(mem_ack)
	);

	fml_sram fml_sram_inst (
		.sys_clk, .hard_reset,
		.mem_stb_i(mem_stb), .mem_req_i(mem_req),
		.mem_ack_o(mem_ack), .mem_rdata_o(mem_rdata)
	);

	// Watches the slave side of the link
	fml_meter fml_meter_inst (
		.sys_clk, .hard_reset,
		.csr_adr_i, .csr_we_i, .csr_wdata_i,
		.csr_rdata_o(csr_rdata_meter),
		.mem_stb_i(mem_stb), .mem_ack_i(mem_ack)
	);

	// Unselected banks read zero
	assign csr_rdata_o = csr_rdata_scan | csr_rdata_meter;

endmodule

// ==== hw/fml_meter.sv ====
/*
 * Link usage meter: strobe and ack cycle counts on the register bus
 */
`timescale 1ns/1ps
`include "fml_settings.svh"

module fml_meter import fml_pkg::*; (
	input  logic      sys_clk,
	input  logic      hard_reset,
	input  csr_adr_t  csr_adr_i,
	input  logic      csr_we_i,
	input  csr_data_t csr_wdata_i,
	output csr_data_t csr_rdata_o,
	input  logic      mem_stb_i,
	input  logic      mem_ack_i
);

	logic csr_sel;
	csr_data_t stb_cnt_q;
	csr_data_t ack_cnt_q;
	csr_data_t rdata_q;

	assign csr_sel = csr_adr_i[`CSR_ADR_W-1 -: `CSR_BANK_W] == `CSR_BANK_W'(`METER_CSR_BANK);

	// ----------------------------------------
	// Counters
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (hard_reset) begin
			stb_cnt_q <= '0;
			ack_cnt_q <= '0;
			rdata_q <= '0;
		end else begin
			// Any write clears, whatever the data
			if (csr_sel && csr_we_i) begin
				stb_cnt_q <= '0;
				ack_cnt_q <= '0;
			end else begin
				// Both saturate at all ones
				if (mem_stb_i && (stb_cnt_q != '1)) begin
					stb_cnt_q <= stb_cnt_q + 1'b1;
				end
				if (mem_ack_i && (ack_cnt_q != '1)) begin
					ack_cnt_q <= ack_cnt_q + 1'b1;
				end
			end
			rdata_q <= '0;
			if (csr_sel) begin
				case (csr_adr_i[1:0])
				2'd0: rdata_q <= stb_cnt_q;
				2'd1: rdata_q <= ack_cnt_q;
				default: rdata_q <= '0;
				endcase
			end
		end
	end

	assign csr_rdata_o = rdata_q;

endmodule

// ==== hw/host_bridge.sv ====
/*
 * Host bridge: 32-bit host accesses to 64-bit link accesses
 */
`timescale 1ns/1ps
`include "fml_settings.svh"

module host_bridge import fml_pkg::*; (
	input  logic       sys_clk,
	input  logic       hard_reset,
	input  logic       host_stb_i,
	input  host_req_t  host_req_i,
	output logic       host_ack_o,
	output host_data_t host_rdata_o,
	output logic       fml_stb_o,
	output fml_req_t   fml_req_o,
	input  logic       fml_ack_i,
	input  fml_data_t  fml_rdata_i
);

	host_state_e state_q;
	fml_req_t req_q;
	logic upper_q;
	host_data_t rdata_q;

	// ----------------------------------------
	// Access FSM
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (hard_reset) begin
			state_q <= HOST_IDLE;
		end else begin
			case (state_q)
			HOST_IDLE: if (host_stb_i) state_q <= HOST_WAIT;
			HOST_WAIT: if (fml_ack_i) state_q <= HOST_DONE;
			// Host drops its strobe while we return to idle
			default: state_q <= HOST_IDLE;
			endcase
		end
	end

	// Request capture and read half
	always_ff @(posedge sys_clk) begin
		if ((state_q == HOST_IDLE) && host_stb_i) begin
			req_q.adr <= host_req_i.adr[`FML_DEPTH:1];
			req_q.we <= host_req_i.we;
			// Same data on both halves, enables pick one
			req_q.wdata <= {host_req_i.wdata, host_req_i.wdata};
			if (host_req_i.adr[0]) begin
				req_q.sel <= {host_req_i.sel, {(`FML_SEL_W/2){1'b0}}};
			end else begin
				req_q.sel <= {{(`FML_SEL_W/2){1'b0}}, host_req_i.sel};
			end
			upper_q <= host_req_i.adr[0];
		end
		if ((state_q == HOST_WAIT) && fml_ack_i) begin
			rdata_q <= upper_q ? fml_rdata_i[`FML_DATA_W-1 -: `HOST_DATA_W]
				: fml_rdata_i[`HOST_DATA_W-1:0];
		end
	end

	// Strobe falls the cycle after the link ack
	assign fml_stb_o = (state_q == HOST_WAIT);
	assign fml_req_o = req_q;
	assign host_ack_o = (state_q == HOST_DONE);
	assign host_rdata_o = rdata_q;

endmodule

// ==== hw/scan_fetch.sv ====
/*
 * Scanout reader: streams a block of link words, set up over the register bus
 */
`timescale 1ns/1ps
`include "fml_settings.svh"

module scan_fetch import fml_pkg::*; (
	input  logic      sys_clk,
	input  logic      hard_reset,
	input  csr_adr_t  csr_adr_i,
	input  logic      csr_we_i,
	input  csr_data_t csr_wdata_i,
	output csr_data_t csr_rdata_o,
	output logic      fml_stb_o,
	output fml_req_t  fml_req_o,
	input  logic      fml_ack_i,
	input  fml_data_t fml_rdata_i,
	output logic      scan_valid_o,
	output fml_data_t scan_data_o
);

	logic csr_sel;
	logic start;
	scan_state_e state_q;
	fml_adr_t base_q;
	logic [`FML_DEPTH:0] count_q;
	fml_adr_t adr_q;
	logic [`FML_DEPTH:0] left_q;
	logic stb_q;
	logic valid_q;
	fml_data_t data_q;
	csr_data_t rdata_q;

	assign csr_sel = csr_adr_i[`CSR_ADR_W-1 -: `CSR_BANK_W] == `CSR_BANK_W'(`SCAN_CSR_BANK);
	assign start = csr_sel && csr_we_i && (csr_adr_i[1:0] == 2'd0) && csr_wdata_i[0];

	// ----------------------------------------
	// Register bank
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (hard_reset) begin
			base_q <= '0;
			count_q <= '0;
			rdata_q <= '0;
		end else begin
			rdata_q <= '0;
			if (csr_sel && csr_we_i) begin
				case (csr_adr_i[1:0])
				2'd1: base_q <= csr_wdata_i[`FML_DEPTH-1:0];
				2'd2: count_q <= csr_wdata_i[`FML_DEPTH:0];
				default: ;
				endcase
			end
			if (csr_sel) begin
				case (csr_adr_i[1:0])
				2'd0: rdata_q <= csr_data_t'(state_q == SCAN_READ);
				2'd1: rdata_q <= csr_data_t'(base_q);
				2'd2: rdata_q <= csr_data_t'(count_q);
				default: rdata_q <= '0;
				endcase
			end
		end
	end

	// ----------------------------------------
	// Fetch FSM
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (hard_reset) begin
			state_q <= SCAN_IDLE;
			stb_q <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			case (state_q)
			SCAN_IDLE: begin
				// Zero count never leaves idle
				if (start && (count_q != '0)) begin
					state_q <= SCAN_READ;
					stb_q <= 1'b1;
				end
			end
			SCAN_READ: begin
				if (fml_ack_i) begin
					stb_q <= 1'b0;
					valid_q <= 1'b1;
					if (left_q == {{`FML_DEPTH{1'b0}}, 1'b1}) begin
						state_q <= SCAN_IDLE;
					end
				end else if (!stb_q) begin
					// One low cycle between requests
					stb_q <= 1'b1;
				end
			end
			default: state_q <= SCAN_IDLE;
			endcase
		end
	end

	// Pass pointer, reloaded while idle
	always_ff @(posedge sys_clk) begin
		if (state_q == SCAN_IDLE) begin
			adr_q <= base_q;
			left_q <= count_q;
		end else if (fml_ack_i) begin
			adr_q <= adr_q + 1'b1;
			left_q <= left_q - 1'b1;
			data_q <= fml_rdata_i;
		end
	end

	// Reads only, all bytes
	assign fml_stb_o = stb_q;
	assign fml_req_o = '{adr: adr_q, we: 1'b0, sel: '1, wdata: '0};
	assign scan_valid_o = valid_q;
	assign scan_data_o = data_q;
	assign csr_rdata_o = rdata_q;

	adr_in_block: assert property (@(posedge sys_clk) disable iff (hard_reset)
		fml_stb_o |-> fml_adr_t'(adr_q - base_q) < count_q)
		else $error("scan address outside programmed block");

endmodule

// ==== hw/fml_sram.sv ====
/*
 * On-chip 64-bit memory on the link, byte enables, fixed ack latency
 */
`timescale 1ns/1ps
`include "fml_settings.svh"

module fml_sram import fml_pkg::*; (
	input  logic      sys_clk,
	input  logic      hard_reset,
	input  logic      mem_stb_i,
	input  fml_req_t  mem_req_i,
	output logic      mem_ack_o,
	output fml_data_t mem_rdata_o
);

	localparam int LAT_W = $clog2(`SRAM_LATENCY + 1);

	fml_data_t mem_q [2**`FML_DEPTH];
	fml_data_t rdata_q;
	logic [LAT_W-1:0] lat_q;
	logic ack_q;
	logic hit;

	// Last wait cycle, ack follows on the next edge
	assign hit = mem_stb_i && !ack_q && (lat_q == LAT_W'(`SRAM_LATENCY - 1));

	// ----------------------------------------
	// Latency counter
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (hard_reset) begin
			lat_q <= '0;
			ack_q <= 1'b0;
		end else begin
			ack_q <= hit;
			if (hit) begin
				lat_q <= '0;
			end else if (mem_stb_i && !ack_q) begin
				lat_q <= lat_q + 1'b1;
			end
		end
	end

	// Array and read data
	always_ff @(posedge sys_clk) begin
		if (hit) begin
			rdata_q <= mem_q[mem_req_i.adr];
			if (mem_req_i.we) begin
				for (int i = 0; i < `FML_SEL_W; i++) begin
					// Enabled bytes only
					if (mem_req_i.sel[i]) begin
						mem_q[mem_req_i.adr][i*8 +: 8] <= mem_req_i.wdata[i*8 +: 8];
					end
				end
			end
		end
	end

	assign mem_ack_o = ack_q;
	assign mem_rdata_o = rdata_q;

	// Master keeps strobing until it has seen the ack
	stb_held: assert property (@(posedge sys_clk) disable iff (hard_reset)
		mem_stb_i && !ack_q |=> mem_stb_i)
		else $error("link strobe dropped before ack");

endmodule

// ==== hw/fml_arbiter.sv ====
/*
 * Link arbiter: fixed priority, scanout over host, one owner per request
 */
`timescale 1ns/1ps

module fml_arbiter import fml_pkg::*; (
	input  logic     sys_clk,
	input  logic     hard_reset,
	// Scanout reader, high priority
	input  logic     scan_stb_i,
	input  fml_req_t scan_req_i,
	output logic     scan_ack_o,
	// Host bridge
	input  logic     host_stb_i,
	input  fml_req_t host_req_i,
	output logic     host_ack_o,
	// Memory side
	output logic     mem_stb_o,
	output fml_req_t mem_req_o,
	input  logic     mem_ack_i
);

	arb_owner_e owner_q;

	// ----------------------------------------
	// Owner register
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (hard_reset) begin
			owner_q <= OWN_NONE;
		end else begin
			case (owner_q)
			OWN_NONE: begin
				// Scan wins a tie
				if (scan_stb_i) begin
					owner_q <= OWN_SCAN;
				end else if (host_stb_i) begin
					owner_q <= OWN_HOST;
				end
			end
			default: begin
				// Released only once the slave has acked
				if (mem_ack_i) begin
					owner_q <= OWN_NONE;
				end
			end
			endcase
		end
	end

	// ----------------------------------------
	// Request and ack routing
	// ----------------------------------------
	always_comb begin
		case (owner_q)
		OWN_SCAN: mem_stb_o = scan_stb_i;
		OWN_HOST: mem_stb_o = host_stb_i;
		default:  mem_stb_o = 1'b0;
		endcase
		// Request is a don't-care with no owner
		mem_req_o = (owner_q == OWN_HOST) ? host_req_i : scan_req_i;
	end

	// Ack goes back to the owner only
	assign scan_ack_o = mem_ack_i && (owner_q == OWN_SCAN);
	assign host_ack_o = mem_ack_i && (owner_q == OWN_HOST);

	// Slave must never answer a request nobody owns
	ack_has_owner: assert property (@(posedge sys_clk) disable iff (hard_reset)
		mem_ack_i |-> owner_q != OWN_NONE)
		else $error("memory ack with no link owner");

endmodule

// ==== hw/fml_pkg.sv ====
/*
 * Shared types of the memory link slice
 */
`include "fml_settings.svh"

package fml_pkg;

	// Link side
	typedef logic [`FML_DEPTH-1:0] fml_adr_t;
	typedef logic [`FML_DATA_W-1:0] fml_data_t;
	typedef logic [`FML_SEL_W-1:0] fml_sel_t;

	// What a master holds stable with its strobe
	typedef struct packed {
		fml_adr_t adr;
		logic we;
		fml_sel_t sel;
		fml_data_t wdata;
	} fml_req_t;

	// Host side, one extra address bit picks the 32-bit half
	typedef logic [`FML_DEPTH:0] host_adr_t;
	typedef logic [`HOST_DATA_W-1:0] host_data_t;
	typedef logic [`HOST_DATA_W/8-1:0] host_sel_t;

	typedef struct packed {
		host_adr_t adr;
		logic we;
		host_sel_t sel;
		host_data_t wdata;
	} host_req_t;

	// Register bus
	typedef logic [`CSR_ADR_W-1:0] csr_adr_t;
	typedef logic [`CSR_DATA_W-1:0] csr_data_t;

	// FSM states
	typedef enum logic [1:0] {OWN_NONE, OWN_SCAN, OWN_HOST} arb_owner_e;
	typedef enum logic {SCAN_IDLE, SCAN_READ} scan_state_e;
	typedef enum logic [1:0] {HOST_IDLE, HOST_WAIT, HOST_DONE} host_state_e;

endpackage

// ==== hw/fml_settings.svh ====
/*
 * Fast memory link slice: widths, depth, latency and register banks
 */
`ifndef FML_SETTINGS_SVH
`define FML_SETTINGS_SVH

// ----------------------------------------
// Memory link
// ----------------------------------------
// Word address width, in 64-bit words
`define FML_DEPTH 10
`define FML_DATA_W 64
`define FML_SEL_W 8
// Cycles from first strobe cycle to ack
`define SRAM_LATENCY 2

// Host side bus
`define HOST_DATA_W 32

// ----------------------------------------
// Register bus
// ----------------------------------------
`define CSR_ADR_W 14
`define CSR_DATA_W 32
// Bank number sits in the top address bits
`define CSR_BANK_W 4
`define SCAN_CSR_BANK 3
`define METER_CSR_BANK 10

`endif
